// File: logic/busPkg.sv
package busPkg;

	typedef logic [23:8] cpuAddr_t;	// cpu address, low byte not decoded
	typedef logic [3:0] addrRegion_t;	// 1 MB region, A[23:20]
	typedef logic [1:0] waitCnt_t;	// memory wait-state counter

	localparam waitCnt_t ROM_WAIT = 2'd2;	// cycle start to dtack, rom
	localparam waitCnt_t RAM_WAIT = 2'd1;	// cycle start to dtack, ram

	// one bit per decoded target
	typedef struct packed {
		logic rom;	// rom, incl. boot overlay at 0
		logic rom4x;	// rom window at 4xxxxx
		logic ram;	// main ram, overlay off
		logic ram0x;	// low 4 MB window
		logic io;	// goes to the i/o board
		logic ioPostedWrite;	// write into low window
		logic iack;	// interrupt acknowledge space
		logic sndWrite;	// write into sound buffer
	} devSelect_t;

	// request handed to the i/o board
	typedef struct packed {
		cpuAddr_t addr;
		logic write;
		logic iack;
		logic posted;	// cpu already released
	} ioReq_t;

	typedef enum logic [1:0] {
		dtIdle,	// no cycle
		dtCounting,	// memory wait states
		dtWaitIo,	// waiting on i/o completion
		dtAsserted	// dtack low until strobe ends
	} dtackState_t;

	typedef enum logic [1:0] {
		brEmpty,	// nothing queued or in flight
		brOffering,	// ioValid high
		brOutstanding	// transferred, waiting for ioDone
	} bridgeState_t;

endpackage

// File: logic/cycleDetect.sv
`timescale 1ns/1ps

module cycleDetect (
	input logic CLK,
	input logic reset,
	input logic nAS,
	output logic cycleActive,
	output logic cycleStart
);

	logic asMeta;	// first sync stage, metastable
	logic asSync;	// second sync stage
	logic asPrev;	// last clock's level

	// strobe comes from the cpu clock domain
	always_ff @(posedge CLK) begin
		if (reset) begin
			asMeta <= 1'b0;
			asSync <= 1'b0;
		end else begin
			asMeta <= !nAS;	// active high inside
			asSync <= asMeta;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			asPrev <= 1'b0;
		end else begin
			asPrev <= asSync;
		end
	end

	assign cycleActive = asSync;	// BACT
	assign cycleStart = asSync && !asPrev;	// rising edge only

endmodule

// File: logic/chipSelect.sv
`timescale 1ns/1ps

module chipSelect (
	input logic CLK,
	input logic reset,
	input busPkg::cpuAddr_t A,
	input logic nWE,
	input logic cycleActive,
	output busPkg::devSelect_t sel
);

	busPkg::addrRegion_t region;
	logic overlayOff;	// boot rom no longer at 0
	logic overlay;
	logic rom4xSeen;	// 4x rom hit during this cycle
	logic sndPage;	// sound pages inside 3Fxxxx

	assign region = A[23:20];
	assign overlay = !overlayOff;

	// leave overlay once the first 4x rom cycle is over
	always_ff @(posedge CLK) begin
		if (reset) begin
			overlayOff <= 1'b0;	// overlay active after reset
			rom4xSeen <= 1'b0;
		end else if (cycleActive) begin
			if (sel.rom4x) begin
				rom4xSeen <= 1'b1;
			end
		end else begin
			if (rom4xSeen) begin
				overlayOff <= 1'b1;	// sticky until reset
			end
			rom4xSeen <= 1'b0;
		end
	end

	// sound buffers sit at the top of the two screen pages
	always_comb begin
		case (A[15:8])
			8'hFD, 8'hFE, 8'hFF: sndPage = 1'b1;	// main buffer
			8'hA1, 8'hA2, 8'hA3: sndPage = 1'b1;	// alternate buffer
			default: sndPage = 1'b0;
		endcase
	end

	always_comb begin
		sel = '0;

		// rom
		sel.rom4x = (region == 4'h4);
		sel.rom = sel.rom4x || ((region == 4'h0) && overlay);

		// ram
		sel.ram0x = (A[23:22] == 2'b00);
		sel.ram = sel.ram0x && !overlay;
		sel.sndWrite = sel.ram && !nWE && (A[23:16] == 8'h3F) && sndPage;

		// i/o board
		sel.iack = (A[23:18] == 6'h3F);	// FCxxxx and up
		sel.ioPostedWrite = sel.ram0x && !nWE;
		case (region)
			4'h0, 4'h1, 4'h2, 4'h3: sel.io = 1'b1;	// ram window, seen by i/o board too
			4'h4: sel.io = overlay;	// only while rom is mirrored
			4'h5: sel.io = 1'b1;	// scsi
			4'h6, 4'h7, 4'h8: sel.io = 1'b1;	// unused
			4'h9: sel.io = 1'b1;	// scc read
			4'hA: sel.io = 1'b1;	// unused
			4'hB: sel.io = 1'b1;	// scc write
			4'hC: sel.io = 1'b1;	// unused
			4'hD: sel.io = 1'b1;	// iwm
			4'hE: sel.io = 1'b1;	// via
			4'hF: sel.io = 1'b1;	// iack
			default: sel.io = 1'b0;
		endcase
	end

endmodule

// File: logic/ioBridge.sv
`timescale 1ns/1ps

module ioBridge (
	input logic CLK,
	input logic reset,
	input logic cycleStart,
	input busPkg::cpuAddr_t A,
	input logic nWE,
	input busPkg::devSelect_t sel,
	output logic ioValid,
	input logic ioReady,
	output busPkg::ioReq_t ioReq,
	input logic ioDone,
	output logic ioComplete
);

	busPkg::bridgeState_t state;
	busPkg::ioReq_t reqBuf;	// one-entry request buffer
	logic reqPending;	// captured, not yet offered
	logic postedOut;	// in-flight request is posted
	logic newReq;

	// io only when neither memory wins the priority
	assign newReq = cycleStart && sel.io && !sel.ram && !sel.rom;

	// payload, no reset needed
	always_ff @(posedge CLK) begin
		if (newReq) begin
			reqBuf.addr <= A;
			reqBuf.write <= !nWE;
			reqBuf.iack <= sel.iack;
			reqBuf.posted <= sel.ioPostedWrite;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= busPkg::brEmpty;
			reqPending <= 1'b0;
			postedOut <= 1'b0;
			ioComplete <= 1'b0;
		end else begin
			ioComplete <= 1'b0;	// single-cycle pulse
			case (state)
				busPkg::brEmpty: begin
					if (newReq) begin
						state <= busPkg::brOffering;
					end
				end
				busPkg::brOffering: begin
					if (ioReady) begin	// transfer
						state <= busPkg::brOutstanding;
						postedOut <= reqBuf.posted;
						if (reqBuf.posted) begin
							ioComplete <= 1'b1;	// release cpu early
						end
					end
				end
				busPkg::brOutstanding: begin
					if (ioDone) begin
						if (!postedOut) begin
							ioComplete <= 1'b1;
						end
						if (newReq || reqPending) begin	// queued behind posted write
							state <= busPkg::brOffering;
							reqPending <= 1'b0;
						end else begin
							state <= busPkg::brEmpty;
						end
					end else if (newReq) begin
						reqPending <= 1'b1;	// hold until ioDone
					end
				end
				default: state <= busPkg::brEmpty;
			endcase
		end
	end

	assign ioValid = (state == busPkg::brOffering);
	assign ioReq = reqBuf;	// stable while offering

endmodule

// File: logic/dtackGen.sv
`timescale 1ns/1ps

module dtackGen (
	input logic CLK,
	input logic reset,
	input logic cycleStart,
	input logic cycleActive,
	input busPkg::devSelect_t sel,
	input logic ioComplete,
	output logic nDTACK
);

	busPkg::dtackState_t state;
	busPkg::waitCnt_t waitCnt;	// remaining memory waits

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= busPkg::dtIdle;
			waitCnt <= '0;
			nDTACK <= 1'b1;
		end else if (!cycleActive) begin
			state <= busPkg::dtIdle;	// strobe gone, release bus
			nDTACK <= 1'b1;
		end else begin
			case (state)
				busPkg::dtIdle: begin
					if (cycleStart) begin
						if (sel.ram) begin	// ram first
							state <= busPkg::dtCounting;
							waitCnt <= busPkg::RAM_WAIT - 1'b1;	// load clock is one wait
						end else if (sel.rom) begin
							state <= busPkg::dtCounting;
							waitCnt <= busPkg::ROM_WAIT - 1'b1;
						end else begin	// everything else is i/o
							state <= busPkg::dtWaitIo;
						end
					end
				end
				busPkg::dtCounting: begin
					if (waitCnt == '0) begin
						state <= busPkg::dtAsserted;
						nDTACK <= 1'b0;	// wait+1 clocks after start
					end else begin
						waitCnt <= waitCnt - 1'b1;
					end
				end
				busPkg::dtWaitIo: begin
					if (ioComplete) begin	// latency set by i/o board
						state <= busPkg::dtAsserted;
						nDTACK <= 1'b0;
					end
				end
				busPkg::dtAsserted: begin
					nDTACK <= 1'b0;	// hold until strobe ends
				end
				default: state <= busPkg::dtIdle;
			endcase
		end
	end

endmodule

// File: logic/busDecodeTop.sv
`timescale 1ns/1ps

module busDecodeTop (
	input logic CLK,
	input logic reset,
	input busPkg::cpuAddr_t A,
	input logic nAS,
	input logic nWE,
	input logic ioReady,
	input logic ioDone,
	output busPkg::devSelect_t sel,
	output logic nDTACK,
	output logic ioValid,
	output busPkg::ioReq_t ioReq
);

	logic cycleActive;	// synchronized strobe
	logic cycleStart;
	logic ioComplete;	// bridge done, cpu may go

	cycleDetect i_cycleDetect (
		.CLK(CLK),
		.reset(reset),
		.nAS(nAS),
		.cycleActive(cycleActive),
		.cycleStart(cycleStart)
	);

	chipSelect i_chipSelect (
		.CLK(CLK),
		.reset(reset),
		.A(A),
		.nWE(nWE),
		.cycleActive(cycleActive),
		.sel(sel)
	);

	ioBridge i_ioBridge (
		.CLK(CLK),
		.reset(reset),
		.cycleStart(cycleStart),
		.A(A),
		.nWE(nWE),
		.sel(sel),
		.ioValid(ioValid),
		.ioReady(ioReady),
		.ioReq(ioReq),
		.ioDone(ioDone),
		.ioComplete(ioComplete)
	);

	dtackGen i_dtackGen (
		.CLK(CLK),
		.reset(reset),
		.cycleStart(cycleStart),
		.cycleActive(cycleActive),
		.sel(sel),
		.ioComplete(ioComplete),
		.nDTACK(nDTACK)
	);

endmodule

// File: test/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, A[23:8], write, expected sel, target, max ioReady stall
// sel bits, msb first: rom rom4x ram ram0x io ioPostedWrite iack sndWrite
task automatic loadVectors();
	// overlay active after reset
	addRow("ovlRomRead", 16'h0000, 1'b0, 8'b1001_1000, tgtRom, 4'd0);	// boot rom at 0
	addRow("ovlIoRead2", 16'h2000, 1'b0, 8'b0001_1000, tgtIo, 4'd3);	// low window to i/o board
	// region 1, since region 0 is boot rom while overlaid
	addRow("postedWrite", 16'h1000, 1'b1, 8'b0001_1100, tgtPosted, 4'd2);
	addRow("queuedRead5", 16'h5000, 1'b0, 8'b0000_1000, tgtIo, 4'd1);	// waits behind posted
	addRow("ovlStillOn", 16'h0001, 1'b0, 8'b1001_1000, tgtRom, 4'd0);
	addRow("rom4xExit", 16'h4000, 1'b0, 8'b1100_1000, tgtRom, 4'd0);	// overlay ends after this

	// overlay off from here
	addRow("ramAtZero", 16'h0000, 1'b0, 8'b0011_1000, tgtRam, 4'd0);
	addRow("ramWrite1", 16'h1000, 1'b1, 8'b0011_1100, tgtRam, 4'd0);
	addRow("ramRead3", 16'h3000, 1'b0, 8'b0011_1000, tgtRam, 4'd0);
	addRow("rom4xOnly", 16'h41F0, 1'b0, 8'b1100_0000, tgtRom, 4'd0);	// no io once overlay is gone
	addRow("ioReadA", 16'hA000, 1'b0, 8'b0000_1000, tgtIo, 4'd0);
	addRow("ioReadE", 16'hE000, 1'b0, 8'b0000_1000, tgtIo, 4'd4);	// via, long stall
	addRow("iackRead", 16'hFFFF, 1'b0, 8'b0000_1010, tgtIo, 4'd2);
	addRow("ioWriteD", 16'hD000, 1'b1, 8'b0000_1000, tgtIo, 4'd3);	// not posted, above low window
	addRow("ioReadF8", 16'hF800, 1'b0, 8'b0000_1000, tgtIo, 4'd1);	// just below iack space

	// sound buffer window
	addRow("sndMain", 16'h3FFD, 1'b1, 8'b0011_1101, tgtRam, 4'd0);
	addRow("sndAlt", 16'h3FA2, 1'b1, 8'b0011_1101, tgtRam, 4'd0);
	addRow("sndMiss", 16'h3F80, 1'b1, 8'b0011_1100, tgtRam, 4'd0);	// page outside buffer
	addRow("sndRead", 16'h3FFD, 1'b0, 8'b0011_1000, tgtRam, 4'd0);	// reads never flag
endtask

`endif

// File: test/tbBusDecode.sv
`timescale 1ns/1ps

module tbBusDecode;

	typedef enum logic [1:0] {tgtRom, tgtRam, tgtIo, tgtPosted} targetClass_t;

	typedef struct packed {
		busPkg::cpuAddr_t addr;
		logic write;
		busPkg::devSelect_t expSel;
		targetClass_t target;
		logic [3:0] maxStall;	// upper bound of the ioReady stall
	} vecRow_t;

	logic CLK;
	logic reset;
	busPkg::cpuAddr_t A;
	logic nAS;
	logic nWE;
	logic ioReady;
	logic ioDone;
	busPkg::devSelect_t sel;
	logic nDTACK;
	logic ioValid;
	busPkg::ioReq_t ioReq;

	string rowName[$];
	vecRow_t rows[$];
	string curName;
	logic [3:0] curMaxStall;
	int clkEdges;	// index of the latest rising edge
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	bit rowFailed;
	bit timedOut = 1'b0;
	integer seed = 32'hbe4f;

	// what the i/o port model saw
	int xferCount;
	busPkg::ioReq_t xferReq;
	int xferEdge;
	int offerEdge;
	int doneAt;	// edge that samples ioDone high
	int postedDoneAt = 0;

	busDecodeTop i_dut (
		.CLK(CLK),
		.reset(reset),
		.A(A),
		.nAS(nAS),
		.nWE(nWE),
		.ioReady(ioReady),
		.ioDone(ioDone),
		.sel(sel),
		.nDTACK(nDTACK),
		.ioValid(ioValid),
		.ioReq(ioReq)
	);

	initial begin
		CLK = 1'b0;
		clkEdges = 0;
		forever begin
			#10;
			clkEdges = clkEdges + 1;	// counted before the edge wakes anyone
			CLK = 1'b1;
			#10;
			CLK = 1'b0;
		end
	end

	task automatic addRow(input string name, input busPkg::cpuAddr_t addr, input logic write,
			input logic [7:0] expSel, input targetClass_t target, input logic [3:0] maxStall);
		vecRow_t row;
		row.addr = addr;
		row.write = write;
		row.expSel = expSel;
		row.target = target;
		row.maxStall = maxStall;
		rowName.push_back(name);
		rows.push_back(row);
	endtask

	`include "tbVectors.svh"

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s %s: expected %0h, actual %0h", curName, what, expected, actual);
			errorCount++;
			rowFailed = 1'b1;
		end
	endtask

	// cycleStart 2 clocks after nAS low, then waits+1
	function automatic int memLatency(input int waits);
		return 2 + waits + 1;
	endfunction

	// sampled on falling edges, away from the rising edge updates
	task automatic waitDtack(input logic level, output int atEdge, output bit ok);
		int waited;
		waited = 0;
		@(negedge CLK);
		while (nDTACK !== level && waited < 100) begin
			@(negedge CLK);
			waited++;
		end
		ok = (nDTACK === level);
		atEdge = clkEdges;
		if (!ok) begin
			$display("Timeout in %s: nDTACK did not go %s within 100 clocks", curName,
				level ? "high" : "low");
		end
	endtask

	task automatic checkIo(input vecRow_t row, input int lowEdge, input int prevPostedDone);
		busPkg::ioReq_t expReq;
		expReq.addr = row.addr;
		expReq.write = row.write;
		expReq.iack = row.expSel.iack;
		expReq.posted = row.expSel.ioPostedWrite;
		checkValue("io transfers", 32'd1, 32'(xferCount));
		checkValue("ioReq", 32'(expReq), 32'(xferReq));
		checkValue("offer after posted ioDone", 32'd1, 32'(offerEdge > prevPostedDone));
		if (row.target == tgtPosted) begin
			checkValue("posted dtack clocks", 32'd1, 32'(lowEdge - xferEdge));	// early release
			checkValue("dtack before ioDone", 32'd1, 32'(lowEdge < postedDoneAt));
		end else begin
			checkValue("io dtack clocks", 32'd1, 32'(lowEdge - doneAt));
		end
	endtask

	task automatic runRow(input int idx);
		vecRow_t row;
		int startEdge;
		int lowEdge;
		int highEdge;
		int prevPostedDone;
		bit ok;
		row = rows[idx];
		curName = rowName[idx];
		rowFailed = 1'b0;
		xferCount = 0;
		curMaxStall = row.maxStall;
		prevPostedDone = postedDoneAt;	// a posted write from an earlier row
		@(posedge CLK);
		A <= row.addr;
		nWE <= !row.write;
		nAS <= 1'b0;
		startEdge = clkEdges;
		waitDtack(1'b0, lowEdge, ok);
		if (ok) begin
			checkValue("sel", 32'(row.expSel), 32'(sel));
			case (row.target)
				tgtRom: begin
					checkValue("rom latency", 32'(memLatency(int'(busPkg::ROM_WAIT))),
						32'(lowEdge - startEdge));
					checkValue("io transfers", 32'd0, 32'(xferCount));
				end
				tgtRam: begin
					checkValue("ram latency", 32'(memLatency(int'(busPkg::RAM_WAIT))),
						32'(lowEdge - startEdge));
					checkValue("io transfers", 32'd0, 32'(xferCount));
				end
				default: checkIo(row, lowEdge, prevPostedDone);
			endcase
			@(posedge CLK);
			nAS <= 1'b1;	// A stays until the next row
			waitDtack(1'b1, highEdge, ok);
		end
		if (!ok) begin
			timedOut = 1'b1;
		end
		if (!ok || rowFailed) begin
			failCount++;
		end else begin
			passCount++;
		end
		$display("%s %s", curName, (ok && !rowFailed) ? "ok" : "failed");
	endtask

	// i/o board: random stall before ioReady, ioDone some clocks after the transfer
	initial begin
		int stallLeft;
		int delay;
		bit offerSeen;
		bit donePending;
		busPkg::ioReq_t offerReq;
		ioReady <= 1'b0;
		ioDone <= 1'b0;
		offerSeen = 1'b0;
		donePending = 1'b0;
		stallLeft = 0;
		forever begin
			@(posedge CLK);
			if (ioValid && ioReady) begin	// transfer on this edge
				xferCount++;
				xferReq = ioReq;
				xferEdge = clkEdges;
				delay = 1 + ($random(seed) & 3);
				if (ioReq.posted) begin
					delay = delay + 10;	// posted writes drain slowly, next read queues
				end
				doneAt = clkEdges + delay;
				if (ioReq.posted) begin
					postedDoneAt = doneAt;
				end
				donePending = 1'b1;
				offerSeen = 1'b0;
				ioReady <= 1'b0;
			end else if (ioValid && !offerSeen) begin	// new offer
				offerSeen = 1'b1;
				offerEdge = clkEdges;
				offerReq = ioReq;
				stallLeft = ($random(seed) & 32'h7fff_ffff) % (int'(curMaxStall) + 1);
				if (stallLeft == 0) begin
					ioReady <= 1'b1;
				end
			end else if (ioValid) begin	// stalling
				checkValue("ioReq steady", 32'(offerReq), 32'(ioReq));
				if (stallLeft > 0) begin
					stallLeft--;
				end
				if (stallLeft == 0) begin
					ioReady <= 1'b1;
				end
			end
			if (donePending && clkEdges == doneAt - 1) begin
				ioDone <= 1'b1;	// high for one clock
				donePending = 1'b0;
			end else begin
				ioDone <= 1'b0;
			end
		end
	end

	initial begin
		int i;
		reset <= 1'b1;
		A <= '0;
		nAS <= 1'b1;
		nWE <= 1'b1;
		loadVectors();
		repeat (4) @(posedge CLK);
		reset <= 1'b0;
		i = 0;
		while (i < rows.size() && !timedOut) begin
			runRow(i);
			i++;
		end
		$display("%0d tests, %0d ok, %0d failed, %0d errors", passCount + failCount,
			passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0 && !timedOut) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+test
logic/busPkg.sv
logic/cycleDetect.sv
logic/chipSelect.sv
logic/ioBridge.sv
logic/dtackGen.sv
logic/busDecodeTop.sv
test/tbBusDecode.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f vlog.f --top-module tbBusDecode -o simBusDecode

./obj_dir/simBusDecode > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
